// ==== all.f ====
+incdir+design
design/ntt_ctrl_pkg.sv
design/coeff_loader.sv
design/phase_sequencer.sv
design/exec_scheduler.sv
design/ntt_ctrl_top.sv
tb/tb_clk_gen.sv
tb/tb_ntt_ctrl_checks.sv
tb/tb_ntt_ctrl.sv

// ==== design/coeff_loader.sv ====
`timescale 1ns/1ps

`include "ntt_ctrl_consts.svh"

module coeff_loader (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    load_en,        // High through the whole LOAD phase
    input  logic                    valid_input,    // One strobe per pair
    input  ntt_ctrl_pkg::in_word_t  din,            // Held for 8 strobes
    output ntt_ctrl_pkg::coeff_t    din_load_a,
    output ntt_ctrl_pkg::coeff_t    din_load_b,
    output ntt_ctrl_pkg::bram_addr_t addr_load_a,
    output ntt_ctrl_pkg::bram_addr_t addr_load_b,
    output ntt_ctrl_pkg::bank_we_t  load_we,
    output logic                    load_done
);

    ntt_ctrl_pkg::coeff_t    coeff_arr [`NTT_COEFFS_PER_WORD];

    ntt_ctrl_pkg::pair_idx_t pair_cnt;     // Pair inside the current word
    ntt_ctrl_pkg::word_idx_t word_cnt;     // Word inside the current bank
    ntt_ctrl_pkg::bank_idx_t bank_cnt;     // Bank being filled

    logic load_fire;
    logic pair_wrap;
    logic word_wrap;
    logic bank_wrap;

    // Split the input word, coefficient 0 sits in the MSBs
    always_comb begin
        for (int i = 0; i < `NTT_COEFFS_PER_WORD; i++) begin
            coeff_arr[i] = din[`NTT_INPUT_W - 1 - i*`NTT_DATA_W -: `NTT_DATA_W];
        end
    end

    assign load_fire = load_en && valid_input;

    // Wrap points of the nested counters
    assign pair_wrap = (pair_cnt == ntt_ctrl_pkg::pair_idx_t'(`NTT_PAIRS_PER_WORD - 1));
    assign word_wrap = (word_cnt == ntt_ctrl_pkg::word_idx_t'(`NTT_WORDS_PER_BANK - 1));
    assign bank_wrap = (bank_cnt == ntt_ctrl_pkg::bank_idx_t'(`NTT_BANKS - 1));

    // Pair -> word -> bank counters, held at zero outside LOAD
    always_ff @(posedge clk_i) begin
        if (rst_i || !load_en) begin
            pair_cnt <= '0;
            word_cnt <= '0;
            bank_cnt <= '0;
        end else if (valid_input) begin
            if (pair_wrap) begin
                pair_cnt <= '0;
                if (word_wrap) begin
                    word_cnt <= '0;
                    bank_cnt <= bank_wrap ? '0 : bank_cnt + 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else begin
                pair_cnt <= pair_cnt + 1'b1;
            end
        end
    end

    // Pair data and addresses, updated only on a strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            din_load_a  <= '0;
            din_load_b  <= '0;
            addr_load_a <= '0;
            addr_load_b <= '0;
        end else if (load_fire) begin
            din_load_a  <= coeff_arr[{pair_cnt, 1'b0}];     // Even coefficient 2p
            din_load_b  <= coeff_arr[{pair_cnt, 1'b1}];     // Odd coefficient 2p+1
            addr_load_a <= {word_cnt, pair_cnt, 1'b0};      // word*16 + p*2
            addr_load_b <= {word_cnt, pair_cnt, 1'b1};      // Next row for port B
        end
    end

    // Enables last a single cycle per strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            load_we   <= '0;
            load_done <= 1'b0;
        end else begin
            load_we   <= load_fire ? ntt_ctrl_pkg::bank_we_t'(1) << bank_cnt : '0;
            // Flags the 128th pair write in the same cycle
            load_done <= load_fire && pair_wrap && word_wrap && bank_wrap;
        end
    end

endmodule

// ==== design/exec_scheduler.sv ====
`timescale 1ns/1ps

`include "ntt_ctrl_consts.svh"

module exec_scheduler (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   exec_en,            // High for the whole EXEC phase
    input  ntt_ctrl_pkg::bank_we_t load_we,            // One-hot enables from the loader
    output logic                   start_bu_choose,
    output logic                   start_bram_write,
    output logic                   exec_last,
    output ntt_ctrl_pkg::bank_we_t we
);

    ntt_ctrl_pkg::exec_cnt_t exec_cnt;     // Cycle inside the execute window
    ntt_ctrl_pkg::bu_cnt_t   bu_cnt;       // Butterfly cycle inside one write-back period

    logic bu_wrap;

    // Window length is fixed, the last cycle carries no butterfly
    assign exec_last       = exec_en &&
                             (exec_cnt == ntt_ctrl_pkg::exec_cnt_t'(`NTT_EXEC_CYCLE - 1));
    assign start_bu_choose = exec_en && !exec_last;

    assign bu_wrap = (bu_cnt == ntt_ctrl_pkg::bu_cnt_t'(`NTT_BU_LATE - 1));

    // Execute cycle counter
    always_ff @(posedge clk_i) begin
        if (rst_i || !exec_en) begin
            exec_cnt <= '0;
        end else begin
            exec_cnt <= exec_cnt + 1'b1;
        end
    end

    // Butterfly counter, advances on butterfly cycles only
    always_ff @(posedge clk_i) begin
        if (rst_i || !exec_en) begin
            bu_cnt <= '0;
        end else if (start_bu_choose) begin
            bu_cnt <= bu_wrap ? '0 : bu_cnt + 1'b1;
        end
    end

    // Write-back on butterfly cycles 7, 14, ... 119
    assign start_bram_write = start_bu_choose && bu_wrap;

    // All banks take the write-back, loader enables otherwise
    assign we = start_bram_write ? '1 : load_we;

endmodule

// ==== design/ntt_ctrl_consts.svh ====
`ifndef NTT_CTRL_CONSTS_SVH
`define NTT_CTRL_CONSTS_SVH

// Coefficient and bank geometry
`define NTT_DATA_W              12      // One coefficient
`define NTT_ADDR_W              5       // Depth of one bank is 32
`define NTT_COEFFS_PER_WORD     16
`define NTT_INPUT_W             192     // 16 x 12 bit coefficients
`define NTT_PAIRS_PER_WORD      8       // Even/odd pairs per input word
`define NTT_WORDS_PER_BANK      2
`define NTT_BANKS               8

// Phase latencies, in clock cycles or pulses
`define NTT_DECO_LATE           2       // Address generator done pulses
`define NTT_BU_LATE             7       // Butterfly cycles between write-backs
`define NTT_EXEC_CYCLE          120     // Whole execute window

// 8 banks x 2 words x 8 pairs = 128 pair writes = 256 coefficients
// Address layout per bank is {word, pair, port}, so
// NTT_ADDR_W has to stay log2(WORDS_PER_BANK * COEFFS_PER_WORD)
// and COEFFS_PER_WORD has to stay 2 * PAIRS_PER_WORD
// INPUT_W is COEFFS_PER_WORD * DATA_W

`endif

// ==== design/ntt_ctrl_pkg.sv ====
package ntt_ctrl_pkg;

`include "ntt_ctrl_consts.svh"

    // Data path
    typedef logic [`NTT_DATA_W-1:0]  coeff_t;      // One coefficient
    typedef logic [`NTT_INPUT_W-1:0] in_word_t;    // Coefficient 0 in the top bits
    typedef logic [`NTT_ADDR_W-1:0]  bram_addr_t;
    typedef logic [`NTT_BANKS-1:0]   bank_we_t;    // Bit n enables bank n

    // Load counters
    typedef logic [$clog2(`NTT_PAIRS_PER_WORD)-1:0] pair_idx_t;
    typedef logic [$clog2(`NTT_WORDS_PER_BANK)-1:0] word_idx_t;
    typedef logic [$clog2(`NTT_BANKS)-1:0]          bank_idx_t;

    // Execute timing
    typedef logic [$clog2(`NTT_EXEC_CYCLE)-1:0] exec_cnt_t;   // 0 .. EXEC_CYCLE-1
    typedef logic [$clog2(`NTT_BU_LATE)-1:0]    bu_cnt_t;     // 0 .. BU_LATE-1

    // Top level phases
    typedef enum logic [2:0] {
        IDLE = 3'b000,      // Waiting for start
        LOAD = 3'b001,      // Filling the banks
        DECO = 3'b010,      // Address generator running
        EXEC = 3'b011,      // Butterfly window
        DONE = 3'b110       // One cycle completion
    } ctrl_phase_e;

endpackage

// ==== design/ntt_ctrl_top.sv ====
`timescale 1ns/1ps

module ntt_ctrl_top (
    input  logic                     clk_i,
    input  logic                     rst_i,

    // Control from the host side
    input  logic                     start,
    input  logic                     is_ntt,
    input  logic                     valid_input,
    input  ntt_ctrl_pkg::in_word_t   din,
    input  logic                     done_gen_addr,

    // Bank load port
    output ntt_ctrl_pkg::coeff_t     din_load_a,
    output ntt_ctrl_pkg::coeff_t     din_load_b,
    output ntt_ctrl_pkg::bram_addr_t addr_load_a,
    output ntt_ctrl_pkg::bram_addr_t addr_load_b,
    output ntt_ctrl_pkg::bank_we_t   we,

    // Phase strobes and levels
    output logic                     start_bram_load,
    output logic                     start_decode,
    output logic                     start_bram_exec,
    output logic                     start_bu_choose,
    output logic                     start_bram_write,
    output logic                     is_ntt_mode,
    output logic                     done_all
);

    logic                   load_en;       // Sequencer -> loader
    logic                   load_done;     // Loader -> sequencer
    logic                   exec_en;       // Sequencer -> scheduler
    logic                   exec_last;     // Scheduler -> sequencer
    ntt_ctrl_pkg::bank_we_t load_we;       // Loader -> scheduler merge

    coeff_loader u_loader (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .load_en     (load_en),
        .valid_input (valid_input),
        .din         (din),
        .din_load_a  (din_load_a),
        .din_load_b  (din_load_b),
        .addr_load_a (addr_load_a),
        .addr_load_b (addr_load_b),
        .load_we     (load_we),
        .load_done   (load_done)
    );

    phase_sequencer u_seq (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .start           (start),
        .is_ntt          (is_ntt),
        .done_gen_addr   (done_gen_addr),
        .load_done       (load_done),
        .exec_last       (exec_last),
        .load_en         (load_en),
        .exec_en         (exec_en),
        .start_bram_load (start_bram_load),
        .start_decode    (start_decode),
        .start_bram_exec (start_bram_exec),
        .is_ntt_mode     (is_ntt_mode),
        .done_all        (done_all)
    );

    exec_scheduler u_sched (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .exec_en          (exec_en),
        .load_we          (load_we),
        .start_bu_choose  (start_bu_choose),
        .start_bram_write (start_bram_write),
        .exec_last        (exec_last),
        .we               (we)
    );

endmodule

// ==== design/phase_sequencer.sv ====
`timescale 1ns/1ps

`include "ntt_ctrl_consts.svh"

module phase_sequencer (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start,             // Pulse, taken in IDLE only
    input  logic is_ntt,            // 1 = forward NTT, 0 = inverse
    input  logic done_gen_addr,     // Pulses from the address generator
    input  logic load_done,         // Last pair has been written
    input  logic exec_last,         // Final cycle of the execute window
    output logic load_en,
    output logic exec_en,
    output logic start_bram_load,
    output logic start_decode,
    output logic start_bram_exec,
    output logic is_ntt_mode,
    output logic done_all
);

    localparam int DECO_CNT_W = $clog2(`NTT_DECO_LATE + 1);

    ntt_ctrl_pkg::ctrl_phase_e state;

    logic [DECO_CNT_W-1:0] deco_cnt;   // Done pulses seen so far in DECO
    logic                  deco_hit;   // Final pulse needed to leave DECO
    logic                  mode_q;     // Mode sampled with start

    assign deco_hit = (state == ntt_ctrl_pkg::DECO) && done_gen_addr &&
                      (deco_cnt == DECO_CNT_W'(`NTT_DECO_LATE - 1));

    // Phase register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ntt_ctrl_pkg::IDLE;
        end else begin
            case (state)
                ntt_ctrl_pkg::IDLE: begin
                    if (start) begin
                        state <= ntt_ctrl_pkg::LOAD;
                    end
                end
                ntt_ctrl_pkg::LOAD: begin
                    if (load_done) begin
                        state <= ntt_ctrl_pkg::DECO;    // All 8 banks filled
                    end
                end
                ntt_ctrl_pkg::DECO: begin
                    if (deco_hit) begin
                        state <= ntt_ctrl_pkg::EXEC;
                    end
                end
                ntt_ctrl_pkg::EXEC: begin
                    if (exec_last) begin
                        state <= ntt_ctrl_pkg::DONE;
                    end
                end
                ntt_ctrl_pkg::DONE: state <= ntt_ctrl_pkg::IDLE;   // Single cycle
                default:            state <= ntt_ctrl_pkg::IDLE;
            endcase
        end
    end

    // Counts done pulses, restarts every time DECO is entered
    always_ff @(posedge clk_i) begin
        if (rst_i || state != ntt_ctrl_pkg::DECO) begin
            deco_cnt <= '0;
        end else if (done_gen_addr) begin
            deco_cnt <= deco_cnt + 1'b1;
        end
    end

    // Mode latch, only written when a start is accepted
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mode_q <= 1'b0;
        end else if (state == ntt_ctrl_pkg::IDLE && start) begin
            mode_q <= is_ntt;
        end
    end

    // Phase decode
    assign load_en         = (state == ntt_ctrl_pkg::LOAD);
    assign exec_en         = (state == ntt_ctrl_pkg::EXEC);
    assign start_bram_load = (state == ntt_ctrl_pkg::LOAD);
    assign start_decode    = (state == ntt_ctrl_pkg::DECO);
    assign start_bram_exec = (state == ntt_ctrl_pkg::EXEC);
    assign done_all        = (state == ntt_ctrl_pkg::DONE);
    assign is_ntt_mode     = mode_q && (state != ntt_ctrl_pkg::IDLE);   // Held through DONE

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the NTT control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_ntt_ctrl \
    --Mdir "$BUILD_DIR" -o sim_ntt_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_ntt_ctrl" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_i,
    output logic rst_i
);

    localparam int HALF_PERIOD_NS = 4;     // 8 ns clock
    localparam int RST_CYCLES     = 16;

    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD_NS clk_i = ~clk_i;
    end

    // Reset released on a rising edge, like every other input
    initial begin
        rst_i = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
    end

endmodule

// ==== tb/tb_ntt_ctrl.sv ====
`timescale 1ns/1ps

`include "ntt_ctrl_consts.svh"

module tb_ntt_ctrl;

    localparam int PERIOD_NS   = 8;
    localparam int WORDS_TOTAL = `NTT_BANKS * `NTT_WORDS_PER_BANK;
    // Worst run has 3 idle cycles before every strobe and up to 4 before
    // each decode pulse, plus the execute window and slack for start and DONE
    localparam int RUN_CYCLES  = WORDS_TOTAL * `NTT_PAIRS_PER_WORD * 4 +
                                 `NTT_DECO_LATE * 5 + `NTT_EXEC_CYCLE + 16;
    localparam int WATCHDOG_NS = 2 * (16 + 2 * RUN_CYCLES) * PERIOD_NS;

    logic                     clk_i;
    logic                     rst_i;
    logic                     start;
    logic                     is_ntt;
    logic                     valid_input;
    ntt_ctrl_pkg::in_word_t   din;
    logic                     done_gen_addr;
    ntt_ctrl_pkg::coeff_t     din_load_a;
    ntt_ctrl_pkg::coeff_t     din_load_b;
    ntt_ctrl_pkg::bram_addr_t addr_load_a;
    ntt_ctrl_pkg::bram_addr_t addr_load_b;
    ntt_ctrl_pkg::bank_we_t   we;
    logic                     start_bram_load;
    logic                     start_decode;
    logic                     start_bram_exec;
    logic                     start_bu_choose;
    logic                     start_bram_write;
    logic                     is_ntt_mode;
    logic                     done_all;
    logic                     error_flag;
    int                       runs_done;
    integer                   seed;

    tb_clk_gen u_clk (
        .clk_i (clk_i),
        .rst_i (rst_i)
    );

    ntt_ctrl_top u_dut (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .start            (start),
        .is_ntt           (is_ntt),
        .valid_input      (valid_input),
        .din              (din),
        .done_gen_addr    (done_gen_addr),
        .din_load_a       (din_load_a),
        .din_load_b       (din_load_b),
        .addr_load_a      (addr_load_a),
        .addr_load_b      (addr_load_b),
        .we               (we),
        .start_bram_load  (start_bram_load),
        .start_decode     (start_decode),
        .start_bram_exec  (start_bram_exec),
        .start_bu_choose  (start_bu_choose),
        .start_bram_write (start_bram_write),
        .is_ntt_mode      (is_ntt_mode),
        .done_all         (done_all)
    );

    tb_ntt_ctrl_checks u_chk (.*);

    task automatic issue_start(input logic mode);
        @(posedge clk_i);
        start  <= 1'b1;
        is_ntt <= mode;
        @(posedge clk_i);
        start  <= 1'b0;
        is_ntt <= ~mode;        // Latched mode must not follow the input
    endtask

    // 16 random words of 8 strobes each with random gaps of 0 to 3 cycles
    task automatic load_coeffs();
        ntt_ctrl_pkg::in_word_t word;
        int gap;
        for (int w = 0; w < WORDS_TOTAL; w++) begin
            for (int i = 0; i < `NTT_INPUT_W / 32; i++) begin
                word = {word[`NTT_INPUT_W-33:0], 32'($random(seed))};
            end
            for (int p = 0; p < `NTT_PAIRS_PER_WORD; p++) begin
                gap = $random(seed) & 3;
                repeat (gap) begin
                    @(posedge clk_i);
                    valid_input <= 1'b0;
                    start       <= 1'b0;
                end
                @(posedge clk_i);
                valid_input <= 1'b1;
                din         <= word;
                start       <= (w == 4 && p == 0);     // Stray start inside LOAD
            end
        end
        @(posedge clk_i);
        valid_input <= 1'b0;
        start       <= 1'b0;
    endtask

    // Address generator done pulses once decode is requested
    task automatic pulse_gen_done();
        int gap;
        while (!start_decode) @(posedge clk_i);
        repeat (`NTT_DECO_LATE) begin
            gap = 1 + ($random(seed) & 3);
            repeat (gap) @(posedge clk_i);
            done_gen_addr <= 1'b1;
            @(posedge clk_i);
            done_gen_addr <= 1'b0;
        end
    endtask

    task automatic run_transform(input logic mode);
        issue_start(mode);
        load_coeffs();
        pulse_gen_done();
        while (!done_all) @(posedge clk_i);
        @(posedge clk_i);
    endtask

    initial begin
        seed          = 32'hc4c9a953;
        start         = 1'b0;
        is_ntt        = 1'b0;
        valid_input   = 1'b0;
        din           = '0;
        done_gen_addr = 1'b0;
        @(posedge clk_i);                   // Reset is high by the first edge
        while (rst_i) @(posedge clk_i);
        repeat (3) @(posedge clk_i);
        run_transform(1'b1);                // Forward NTT
        repeat (2) @(posedge clk_i);
        run_transform(1'b0);                // Inverse NTT in the opposite mode
        repeat (2) @(posedge clk_i);
        if (error_flag || runs_done != 2) begin
            if (runs_done != 2) begin
                $display("Expected 2 completed runs, saw %0d", runs_done);
            end
            $display("TEST FAILED");
            $fatal(1, "Run ended with errors");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    // First error stops the run
    always @(posedge error_flag) begin
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the runs did not complete", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "Watchdog timeout");
    end

endmodule

// ==== tb/tb_ntt_ctrl_checks.sv ====
`timescale 1ns/1ps

`include "ntt_ctrl_consts.svh"

module tb_ntt_ctrl_checks (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start,
    input  logic                     is_ntt,
    input  logic                     valid_input,
    input  ntt_ctrl_pkg::in_word_t   din,
    input  logic                     done_gen_addr,
    input  ntt_ctrl_pkg::coeff_t     din_load_a,
    input  ntt_ctrl_pkg::coeff_t     din_load_b,
    input  ntt_ctrl_pkg::bram_addr_t addr_load_a,
    input  ntt_ctrl_pkg::bram_addr_t addr_load_b,
    input  ntt_ctrl_pkg::bank_we_t   we,
    input  logic                     start_bram_load,
    input  logic                     start_decode,
    input  logic                     start_bram_exec,
    input  logic                     start_bu_choose,
    input  logic                     start_bram_write,
    input  logic                     is_ntt_mode,
    input  logic                     done_all,
    output logic                     error_flag,
    output int                       runs_done
);

    localparam int PH_IDLE = 0;
    localparam int PH_LOAD = 1;
    localparam int PH_DECO = 2;
    localparam int PH_EXEC = 3;
    localparam int PH_DONE = 4;
    localparam int PAIRS_TOTAL = `NTT_BANKS * `NTT_WORDS_PER_BANK * `NTT_PAIRS_PER_WORD;
    localparam int EXEC_LAST   = `NTT_EXEC_CYCLE - 1;
    localparam int WB_PER_RUN  = EXEC_LAST / `NTT_BU_LATE;      // 17 write-backs
    localparam int ALL_BANKS   = (1 << `NTT_BANKS) - 1;

    // Reference model state, as it stands after the last edge
    int   phase;
    int   load_cnt;       // Pairs accepted in this run
    int   load_fin;       // Last pair written, DECO follows one cycle later
    int   deco_seen;
    int   exec_cyc;       // 0 .. EXEC_LAST
    int   mode;
    int   exp_we, exp_da, exp_db, exp_aa, exp_ab;
    int   exec_len, wr_cnt;    // Per run totals seen on the DUT
    logic model_valid;
    logic check_fail, once_fail, wb_fail;

    initial begin
        model_valid = 1'b0;
        check_fail  = 1'b0;
        once_fail   = 1'b0;
        wb_fail     = 1'b0;
    end

    assign error_flag = check_fail | once_fail | wb_fail;

    // Coefficient idx of a word, coefficient 0 is the top 12 bits
    function automatic int coeff_of(input ntt_ctrl_pkg::in_word_t word, input int idx);
        ntt_ctrl_pkg::in_word_t shifted;
        shifted = word >> (`NTT_DATA_W * (`NTT_COEFFS_PER_WORD - 1 - idx));
        return int'(shifted[`NTT_DATA_W-1:0]);
    endfunction

    task automatic compare_sig(input string name, input int got, input int exp);
        assert (got == exp) else begin
            if (!check_fail) begin
                $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, exp);
            end
            check_fail = 1'b1;
        end
    endtask

    always @(posedge clk_i) begin : model_step
        int p;
        int w;
        int wb;
        if (model_valid) begin
            wb = int'(phase == PH_EXEC && exec_cyc < EXEC_LAST &&
                      (exec_cyc + 1) % `NTT_BU_LATE == 0);
            compare_sig("start_bram_load", int'(start_bram_load), int'(phase == PH_LOAD));
            compare_sig("start_decode", int'(start_decode), int'(phase == PH_DECO));
            compare_sig("start_bram_exec", int'(start_bram_exec), int'(phase == PH_EXEC));
            compare_sig("done_all", int'(done_all), int'(phase == PH_DONE));
            compare_sig("is_ntt_mode", int'(is_ntt_mode), int'(phase != PH_IDLE) & mode);
            compare_sig("start_bu_choose", int'(start_bu_choose),
                        int'(phase == PH_EXEC && exec_cyc < EXEC_LAST));
            compare_sig("start_bram_write", int'(start_bram_write), wb);
            compare_sig("we", int'(we), (wb != 0) ? ALL_BANKS : exp_we);
            compare_sig("din_load_a", int'(din_load_a), exp_da);
            compare_sig("din_load_b", int'(din_load_b), exp_db);
            compare_sig("addr_load_a", int'(addr_load_a), exp_aa);
            compare_sig("addr_load_b", int'(addr_load_b), exp_ab);
            if (start_bram_exec) exec_len++;
            if (start_bram_write) wr_cnt++;
            if (done_all) begin                 // Window totals of the finished run
                compare_sig("execute window length", exec_len, `NTT_EXEC_CYCLE);
                compare_sig("write-back pulses per run", wr_cnt, WB_PER_RUN);
                exec_len = 0;
                wr_cnt   = 0;
                runs_done++;
            end
        end
        if (rst_i) begin
            phase     = PH_IDLE;
            {load_cnt, load_fin, deco_seen, exec_cyc, mode} = '0;
            {exp_we, exp_da, exp_db, exp_aa, exp_ab} = '0;
            {exec_len, wr_cnt, runs_done} = '0;
            model_valid = 1'b1;
        end else begin
            exp_we = 0;                         // Enables last one cycle
            case (phase)
                PH_IDLE: if (start) begin
                    phase    = PH_LOAD;
                    mode     = int'(is_ntt);
                    load_cnt = 0;
                end
                PH_LOAD: if (load_fin != 0) begin
                    phase     = PH_DECO;
                    load_fin  = 0;
                    deco_seen = 0;
                end else if (valid_input) begin
                    p      = load_cnt % `NTT_PAIRS_PER_WORD;
                    w      = (load_cnt / `NTT_PAIRS_PER_WORD) % `NTT_WORDS_PER_BANK;
                    exp_we = 1 << (load_cnt / (`NTT_PAIRS_PER_WORD * `NTT_WORDS_PER_BANK));
                    exp_aa = w * `NTT_COEFFS_PER_WORD + p * 2;
                    exp_ab = exp_aa + 1;
                    exp_da = coeff_of(din, 2 * p);
                    exp_db = coeff_of(din, 2 * p + 1);
                    load_cnt++;
                    if (load_cnt == PAIRS_TOTAL) load_fin = 1;
                end
                PH_DECO: if (done_gen_addr) begin
                    deco_seen++;
                    if (deco_seen == `NTT_DECO_LATE) begin
                        phase    = PH_EXEC;
                        exec_cyc = 0;
                    end
                end
                PH_EXEC: if (exec_cyc == EXEC_LAST) phase = PH_DONE;
                         else exec_cyc++;
                default: phase = PH_IDLE;       // DONE lasts one cycle
            endcase
        end
    end

    // DONE is a single cycle pulse
    assert property (@(posedge clk_i) disable iff (rst_i) done_all |=> !done_all)
        else begin
            $display("done_all stayed high for more than one cycle at %0t ns", $time);
            once_fail = 1'b1;
        end

    // Write-back drives every bank at once
    assert property (@(posedge clk_i) disable iff (rst_i) start_bram_write |-> (we == '1))
        else begin
            $display("Write-back pulse without all bank enables at %0t ns", $time);
            wb_fail = 1'b1;
        end

endmodule
